// File: Bender.yml
package:
  name: cache_subsystem

sources:
  - source/cache_pkg.sv
  - source/cache_fill_ctrl.sv
  - source/cache_tag_array.sv
  - source/cache_data_array.sv
  - source/fill_memory.sv
  - source/cache_subsystem.sv
  - target: test
    files:
      - testbench/cache_subsystem_tb.sv

// File: cache_subsystem.f
source/cache_pkg.sv
source/cache_fill_ctrl.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/fill_memory.sv
source/cache_subsystem.sv
testbench/cache_subsystem_tb.sv

// File: source/cache_data_array.sv
`timescale 1ns/10ps

module cache_data_array (
  input  logic                   clk,         // System clock.
  input  cache_pkg::byte_addr_t  lookup_addr, // Current processor address.
  input  cache_pkg::fill_write_t fill,        // Word write from the fill FSM.
  output cache_pkg::word_t       rdata        // Word at the lookup address.
);
  import cache_pkg::*;

  word_t                 mem [NUM_SETS][WORDS_PER_BLOCK]; // Set by word storage.
  logic [WORD_OFF_W-1:0] rd_word;                         // Word slot of the lookup.

  //////////////////////////////////////////////////
  // Read port.
  //////////////////////////////////////////////////
  // Bit 0 of the offset selects a byte and is not used for words.
  assign rd_word = lookup_addr.offset[OFFSET_W-1:1];

  assign rdata = mem[lookup_addr.index][rd_word]; // Available in the same cycle.

  //////////////////////////////////////////////////
  // Fill port.
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fill.we) begin
      mem[fill.index][fill.word_off] <= fill.data; // One word per returned beat.
    end
  end

endmodule

// File: source/cache_fill_ctrl.sv
`timescale 1ns/10ps

module cache_fill_ctrl (
  input  logic                   clk,       // System clock.
  input  logic                   arst_n,    // Asynchronous reset, active low.
  input  logic                   miss,      // Read request that missed in the tag array.
  input  cache_pkg::byte_addr_t  miss_addr, // Address of the missing read.
  input  cache_pkg::word_t       mem_data,  // Word returned by the backing memory.
  input  logic                   mem_valid, // One cycle pulse with each returned word.
  output logic                   busy,      // Stalls the processor during a fill.
  output logic                   tag_write, // Marks the block valid once complete.
  output cache_pkg::mem_req_t    mem_req,   // Read request to the backing memory.
  output cache_pkg::fill_write_t fill       // Write port of the data array.
);
  import cache_pkg::*;

  typedef enum logic {
    IDLE = 1'b0, // Waiting for a miss.
    WAIT = 1'b1  // Fetching the eight words of the block.
  } state_t;

  state_t             state;          // Current FSM state.
  state_t             nxt_state;      // Next FSM state.
  logic [COUNT_W-1:0] word_count;     // Words written so far in this fill.
  logic [COUNT_W-1:0] nxt_word_count; // Counter value after the edge.
  byte_addr_t         fill_addr;      // Address of the word being fetched.
  byte_addr_t         nxt_fill_addr;  // Fill address after the edge.
  logic               clr_count;      // Starts a new fill.
  logic               incr_cnt;       // A word was accepted this cycle.
  logic               chunks_filled;  // All words of the block are written.

  //////////////////////////////////////////////////
  // Word counter and fill address.
  //////////////////////////////////////////////////
  assign chunks_filled = (word_count == COUNT_W'(WORDS_PER_BLOCK)); // Block complete.

  always_comb begin
    nxt_word_count = word_count; // Hold unless a word arrives.
    nxt_fill_addr  = fill_addr;  // Hold unless a word arrives.
    if (clr_count) begin
      nxt_word_count = '0;                 // New fill starts at word zero.
      nxt_fill_addr  = miss_addr;          // Take tag and index of the miss.
      nxt_fill_addr.offset = '0;           // Align to the start of the block.
    end else if (incr_cnt) begin
      nxt_word_count = word_count + 1'b1;                // One more word written.
      nxt_fill_addr  = byte_addr_t'(fill_addr + 16'd2);  // Step to the next word.
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE; // No fill in progress.
      word_count <= '0;   // Counter starts empty.
      fill_addr  <= '0;   // Request address parked at zero.
    end else begin
      state      <= nxt_state;
      word_count <= nxt_word_count;
      fill_addr  <= nxt_fill_addr;
    end
  end

  //////////////////////////////////////////////////
  // State transitions and outputs.
  //////////////////////////////////////////////////
  always_comb begin
    nxt_state = state; // Stay put by default.
    clr_count = 1'b0;  // No new fill by default.
    incr_cnt  = 1'b0;  // No word accepted by default.
    busy      = 1'b0;  // Processor runs by default.
    tag_write = 1'b0;  // Tag array untouched by default.
    case (state)
      IDLE: begin
        busy      = miss; // Stall in the same cycle as the miss.
        clr_count = miss; // Capture the block address.
        if (miss) begin
          nxt_state = WAIT;
        end
      end
      WAIT: begin
        incr_cnt  = mem_valid & ~chunks_filled; // Accept each returned word.
        busy      = ~chunks_filled;             // Release the stall when the block is in.
        tag_write = chunks_filled;              // Validate the new block.
        if (chunks_filled) begin
          nxt_state = IDLE;
        end
      end
      default: nxt_state = IDLE; // Recover from a corrupted state.
    endcase
  end

  assign mem_req.read  = (state == WAIT) & ~chunks_filled; // Keep asking until done.
  assign mem_req.addr  = fill_addr;                         // Address of the current word.
  assign fill.we       = incr_cnt;                          // Write as each word lands.
  assign fill.index    = fill_addr.index;                   // Set being filled.
  assign fill.word_off = fill_addr.offset[OFFSET_W-1:1];    // Word slot from the byte offset.
  assign fill.data     = mem_data;                          // Pass the memory word through.

endmodule

// File: source/cache_pkg.sv
package cache_pkg;

  //////////////////////////////////////////////////
  // Sizes of the cache and the backing memory.
  //////////////////////////////////////////////////
  localparam int WORD_W          = 16;  // Width of one processor word.
  localparam int TAG_W           = 7;   // Tag bits of a byte address.
  localparam int INDEX_W         = 5;   // Set index bits of a byte address.
  localparam int OFFSET_W        = 4;   // Byte offset bits within one block.
  localparam int WORD_OFF_W      = 3;   // Word offset bits within one block.
  localparam int NUM_SETS        = 32;  // Direct mapped, one block per set.
  localparam int WORDS_PER_BLOCK = 8;   // Words fetched on every fill.
  localparam int COUNT_W         = 4;   // Fill counter reaches WORDS_PER_BLOCK.
  localparam int MEM_WORDS       = 256; // Backing memory depth in words.
  localparam int MEM_ADDR_W      = 8;   // Word address taken from byte address bits 8:1.
  localparam int MEM_LATENCY     = 4;   // Cycles of stable request per returned word.
  localparam int LAT_CNT_W       = $clog2(MEM_LATENCY + 1); // Latency counter width.

  typedef logic [WORD_W-1:0] word_t; // One data word.

  // Byte address split into its cache fields, tag in the top bits.
  typedef struct packed {
    logic [TAG_W-1:0]    tag;    // Compared against the stored tag.
    logic [INDEX_W-1:0]  index;  // Selects the set.
    logic [OFFSET_W-1:0] offset; // Byte within the block; bit 0 is ignored.
  } byte_addr_t;

  typedef struct packed {
    logic             valid; // Set once a block has been filled.
    logic [TAG_W-1:0] tag;   // Tag of the block held in the set.
  } tag_entry_t;

  typedef struct packed {
    logic       read; // Processor read level, held while stalled.
    byte_addr_t addr; // Byte address of the read.
  } cpu_req_t;

  typedef struct packed {
    logic       read; // Held high until the whole block is fetched.
    byte_addr_t addr; // Word aligned fill address.
  } mem_req_t;

  typedef struct packed {
    logic                  we;       // One write per returned word.
    logic [INDEX_W-1:0]    index;    // Set being filled.
    logic [WORD_OFF_W-1:0] word_off; // Word slot inside the block.
    word_t                 data;     // Word from the backing memory.
  } fill_write_t;

  typedef struct packed {
    logic       write; // Single cycle write strobe.
    byte_addr_t addr;  // Byte address of the preloaded word.
    word_t      data;  // Word to place in the backing memory.
  } preload_t;

endpackage

// File: source/cache_subsystem.sv
`timescale 1ns/10ps

module cache_subsystem (
  input  logic                clk,     // System clock.
  input  logic                arst_n,  // Asynchronous reset, active low.
  input  cache_pkg::cpu_req_t cpu_req, // Processor read, held while busy.
  input  cache_pkg::preload_t preload, // Backing memory preload.
  output cache_pkg::word_t    rdata,   // Read data, valid on a hit.
  output logic                hit,     // Request hits in the cache.
  output logic                busy     // Processor stall during a fill.
);
  import cache_pkg::*;

  mem_req_t    mem_req;    // Fill FSM to backing memory.
  word_t       mem_rdata;  // Word returned by the memory.
  logic        mem_rvalid; // Returned word is valid.
  fill_write_t fill;       // Fill FSM to data array.
  logic        tag_write;  // Fill complete, mark the set valid.
  logic        miss;       // Read that does not hit.

  assign miss = cpu_req.read & ~hit; // Only reads can start a fill.

  //////////////////////////////////////////////////
  // Cache arrays.
  //////////////////////////////////////////////////
  cache_tag_array u_tag_array (
    .clk         (clk),
    .arst_n      (arst_n),
    .lookup_addr (cpu_req.addr),
    .tag_write   (tag_write),
    .hit         (hit)
  );

  cache_data_array u_data_array (
    .clk         (clk),
    .lookup_addr (cpu_req.addr),
    .fill        (fill),
    .rdata       (rdata)
  );

  //////////////////////////////////////////////////
  // Miss handling and backing memory.
  //////////////////////////////////////////////////
  cache_fill_ctrl u_fill_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .miss      (miss),
    .miss_addr (cpu_req.addr),
    .mem_data  (mem_rdata),
    .mem_valid (mem_rvalid),
    .busy      (busy),
    .tag_write (tag_write),
    .mem_req   (mem_req),
    .fill      (fill)
  );

  fill_memory u_memory (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (mem_req),
    .preload (preload),
    .rdata   (mem_rdata),
    .rvalid  (mem_rvalid)
  );

endmodule

// File: source/cache_tag_array.sv
`timescale 1ns/10ps

module cache_tag_array (
  input  logic                  clk,         // System clock.
  input  logic                  arst_n,      // Asynchronous reset, active low.
  input  cache_pkg::byte_addr_t lookup_addr, // Current processor address.
  input  logic                  tag_write,   // Stores the lookup tag as valid.
  output logic                  hit          // Valid entry with a matching tag.
);
  import cache_pkg::*;

  tag_entry_t tags [NUM_SETS]; // One entry per set.
  tag_entry_t entry;           // Entry selected by the lookup index.
  tag_entry_t new_entry;       // Entry written at the end of a fill.

  //////////////////////////////////////////////////
  // Lookup.
  //////////////////////////////////////////////////
  assign entry = tags[lookup_addr.index]; // Combinational read of the set.

  // A hit needs a filled block whose tag matches the request.
  assign hit = entry.valid && (entry.tag == lookup_addr.tag);

  //////////////////////////////////////////////////
  // Update.
  //////////////////////////////////////////////////
  assign new_entry.valid = 1'b1;            // A finished fill is always valid.
  assign new_entry.tag   = lookup_addr.tag; // The request is held, so its tag is the fill tag.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_SETS; i++) begin
        tags[i] <= '0; // Every set starts empty.
      end
    end else if (tag_write) begin
      tags[lookup_addr.index] <= new_entry; // Replace whatever the set held.
    end
  end

endmodule

// File: source/fill_memory.sv
`timescale 1ns/10ps

module fill_memory (
  input  logic                clk,     // System clock.
  input  logic                arst_n,  // Asynchronous reset, active low.
  input  cache_pkg::mem_req_t req,     // Read request from the fill FSM.
  input  cache_pkg::preload_t preload, // Contents written from outside.
  output cache_pkg::word_t    rdata,   // Word at the requested address.
  output logic                rvalid   // Pulses once the latency has elapsed.
);
  import cache_pkg::*;

  word_t                 mem [MEM_WORDS]; // Backing store.
  logic [MEM_ADDR_W-1:0] rd_word;         // Word address of the request.
  logic [MEM_ADDR_W-1:0] wr_word;         // Word address of the preload.
  logic [LAT_CNT_W-1:0]  lat_cnt;         // Stable cycles counted before this one.
  logic [LAT_CNT_W-1:0]  run_len;         // Stable cycles including this one.
  byte_addr_t            last_addr;       // Request address of the previous cycle.
  logic                  same_addr;       // Request continues an open count.

  //////////////////////////////////////////////////
  // Address decode.
  //////////////////////////////////////////////////
  assign rd_word = {req.addr.index, req.addr.offset[OFFSET_W-1:1]};         // Bits 8:1.
  assign wr_word = {preload.addr.index, preload.addr.offset[OFFSET_W-1:1]}; // Bits 8:1.

  always_ff @(posedge clk) begin
    if (preload.write) begin
      mem[wr_word] <= preload.data; // Testbench places known contents.
    end
  end

  //////////////////////////////////////////////////
  // Read latency.
  //////////////////////////////////////////////////
  // A count only continues while the address stays the same.
  assign same_addr = (lat_cnt != '0) && (req.addr == last_addr);

  always_comb begin
    run_len = '0; // No request, no count.
    if (req.read) begin
      run_len = same_addr ? lat_cnt + 1'b1 : LAT_CNT_W'(1); // First cycle counts as one.
    end
  end

  assign rvalid = (run_len == LAT_CNT_W'(MEM_LATENCY)); // Last cycle of the wait.
  assign rdata  = mem[rd_word];                         // Sampled together with rvalid.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lat_cnt   <= '0; // No request in flight.
      last_addr <= '0;
    end else begin
      lat_cnt   <= rvalid ? '0 : run_len; // Restart after each returned word.
      last_addr <= req.addr;              // Compared against next cycle.
    end
  end

endmodule

// File: testbench/cache_stim.txt
# P <byte address> <data>                          preload one memory word, hex
# R <byte address> <expected data> <expected miss>  read and check, hex
P 0030 a300
P 0032 a302
P 0034 a304
P 0036 a306
P 0038 a308
P 003a a30a
P 003c a30c
P 003e a30e
P 0074 b774
P 0076 b776
R 0034 a304 1
R 0030 a300 0
R 0031 a300 0
R 0032 a302 0
R 0036 a306 0
R 0038 a308 0
R 003a a30a 0
R 003c a30c 0
R 003e a30e 0
R 0074 b774 1
R 0076 b776 0
R 1234 a304 1
R 1230 a300 0
R 0034 a304 1
R 003e a30e 0

// File: testbench/cache_subsystem_tb.sv
`timescale 1ns/10ps

module cache_subsystem_tb;
  import cache_pkg::*;

  localparam int CLK_PERIOD   = 100; // Clock period in ns.
  localparam int RESET_CYCLES = 3;   // Cycles with arst_n held low.
  localparam int BUSY_TIMEOUT = 100; // Longest wait for a fill to finish.
  // One stall cycle for the miss itself plus one latency window per word.
  localparam int FILL_CYCLES  = WORDS_PER_BLOCK * MEM_LATENCY + 1;

  logic     clk;        // DUT clock.
  logic     arst_n;     // DUT reset.
  cpu_req_t cpu_req;    // Processor read request.
  preload_t preload;    // Backing memory preload port.
  word_t    rdata;      // Read data from the cache.
  logic     hit;        // Cache hit level.
  logic     busy;       // Stall level during a fill.
  int       stim_fd;    // Handle of the stimulus file.
  int       cmd_no;     // Commands read from the stimulus file so far.
  int       reads_done; // Read commands that were checked.

  cache_subsystem UUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .cpu_req (cpu_req),
    .preload (preload),
    .rdata   (rdata),
    .hit     (hit),
    .busy    (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk; // Free running clock.

  //////////////////////////////////////////////////
  // Helper tasks.
  //////////////////////////////////////////////////
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic apply_reset();
    repeat (RESET_CYCLES) @(posedge clk); // Reset spans the first cycles.
    arst_n <= 1'b1;
    @(negedge clk);
    // Nothing is filling right after reset.
    assert (busy == 1'b0)
      else abort_run($sformatf("error: busy = %h after reset, expected %h", busy, 1'b0));
  endtask

  task automatic load_word(input logic [15:0] addr, input word_t data);
    @(posedge clk);
    cpu_req.read  <= 1'b0; // No lookup while the memory is written.
    preload.write <= 1'b1;
    preload.addr  <= byte_addr_t'(addr);
    preload.data  <= data;
    @(posedge clk);
    preload.write <= 1'b0; // Single cycle strobe.
  endtask

  task automatic read_check(input logic [15:0] addr, input word_t exp_data,
                            input logic exp_miss);
    int busy_cycles;
    int waited;
    busy_cycles = 0;
    waited      = 0;
    @(posedge clk);
    preload.write <= 1'b0;
    cpu_req.read  <= 1'b1;
    cpu_req.addr  <= byte_addr_t'(addr); // Held until the next command.
    @(negedge clk); // Outputs settle after the edge.
    assert (hit == !exp_miss)
      else abort_run($sformatf("error: hit = %h, expected %h, address %h",
                               hit, !exp_miss, addr));
    if (exp_miss) begin
      assert (busy == 1'b1)
        else abort_run($sformatf("error: busy = %h on a miss, expected %h, address %h",
                                 busy, 1'b1, addr));
      busy_cycles = 1; // The miss cycle itself stalls.
      while (busy) begin
        @(posedge clk);
        @(negedge clk);
        waited++;
        if (waited > BUSY_TIMEOUT) begin
          abort_run("Timed out waiting for busy to fall after a miss.");
        end
        if (busy) begin
          busy_cycles++;
        end
      end
      assert (busy_cycles == FILL_CYCLES)
        else abort_run($sformatf("error: busy high for %h cycles, expected %h, address %h",
                                 busy_cycles, FILL_CYCLES, addr));
      @(posedge clk); // Tag is written at this edge.
      @(negedge clk);
      assert (hit == 1'b1)
        else abort_run($sformatf("error: hit = %h after the fill, expected %h, address %h",
                                 hit, 1'b1, addr));
      assert (busy == 1'b0)
        else abort_run($sformatf("error: busy = %h after the fill, expected %h, address %h",
                                 busy, 1'b0, addr));
    end else begin
      assert (busy == 1'b0)
        else abort_run($sformatf("error: busy = %h on a hit, expected %h, address %h",
                                 busy, 1'b0, addr));
    end
    assert (rdata == exp_data)
      else abort_run($sformatf("error: rdata = %h, expected %h, address %h",
                               rdata, exp_data, addr));
  endtask

  //////////////////////////////////////////////////
  // Stimulus file reader.
  //////////////////////////////////////////////////
  initial begin
    logic [7:0]  cmd;       // Command character.
    logic [15:0] addr;      // Byte address field.
    logic [15:0] data;      // Data or expected data field.
    logic [15:0] miss_flag; // Expected miss field of a read.
    int          fields;    // Fields that were parsed.
    int          ch;        // Character skipped inside a comment.
    clk        = 1'b0;
    arst_n     = 1'b0;
    cpu_req    = '0;
    preload    = '0;
    cmd_no     = 0;
    reads_done = 0;
    stim_fd = $fopen("testbench/cache_stim.txt", "r");
    if (stim_fd == 0) begin
      abort_run("Could not open the stimulus file testbench/cache_stim.txt.");
    end
    apply_reset();
    fields = $fscanf(stim_fd, " %c", cmd); // Blanks and line ends before a command are skipped.
    while (fields == 1) begin
      if (cmd == "#") begin
        ch = $fgetc(stim_fd); // A comment runs to the end of its line.
        while (ch != "\n" && ch != -1) begin
          ch = $fgetc(stim_fd);
        end
      end else begin
        cmd_no++;
        case (cmd)
          "P": begin
            fields = $fscanf(stim_fd, "%h %h", addr, data);
            if (fields != 2) begin
              abort_run($sformatf("Command %0d is a malformed preload command.", cmd_no));
            end
            load_word(addr, data);
          end
          "R": begin
            fields = $fscanf(stim_fd, "%h %h %h", addr, data, miss_flag);
            if (fields != 3) begin
              abort_run($sformatf("Command %0d is a malformed read command.", cmd_no));
            end
            read_check(addr, data, miss_flag[0]);
            reads_done++;
          end
          default: begin
            abort_run($sformatf("Command %0d is an unknown command.", cmd_no));
          end
        endcase
      end
      fields = $fscanf(stim_fd, " %c", cmd);
    end
    $fclose(stim_fd);
    if (reads_done == 0) begin
      abort_run("The stimulus file held no read commands.");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule
